//--- verilog/idctPkg.sv
package idctPkg;

   //--------------------------------------------------------------------------
   // block geometry
   //--------------------------------------------------------------------------
   localparam int BlockSize = 64;            // coefficients per block
   localparam int PageCount = 8;             // rows per block
   localparam int PageLast  = 7;             // last row index
   localparam int CountLast = 6;             // 7 cycles per row
   localparam int PairCount = 4;             // productive counts per row
   localparam int LaneCount = 8;             // words per stage register file

   // rotation and output scaling
   localparam int RotShift  = 8;             // 181/256 ~ 1/sqrt(2)
   localparam int OutLsb    = 15;            // drop the 2^15 of the two cosine passes

   //--------------------------------------------------------------------------
   // word types
   //--------------------------------------------------------------------------
   typedef logic signed [15:0] coeffWord_t;  // input coefficient
   typedef logic signed [31:0] stageWord_t;  // product or partial sum
   typedef logic signed [42:0] rotWord_t;    // 32 bit sum times 9 bit factor
   typedef logic        [8:0]  outWord_t;    // truncated result

   typedef logic [$clog2(PageCount)-1:0] page_t;
   typedef logic [$clog2(CountLast+1)-1:0] count_t;

   typedef coeffWord_t block_t [BlockSize];  // x(8*page + k) at index 8*page + k

   //--------------------------------------------------------------------------
   // cosine factors, cos(k*pi/16) scaled by 4096
   //--------------------------------------------------------------------------
   localparam coeffWord_t CosC1 = 16'sd4017;
   localparam coeffWord_t CosC2 = 16'sd3784;
   localparam coeffWord_t CosC3 = 16'sd3406;
   localparam coeffWord_t CosC4 = 16'sd2896;
   localparam coeffWord_t CosC5 = 16'sd2276;
   localparam coeffWord_t CosC6 = 16'sd1567;
   localparam coeffWord_t CosC7 = 16'sd799;

   localparam logic signed [8:0] RotFactor = 9'sd181; // positive, msb clear

endpackage

//--- verilog/stageLinkIf.sv
`timescale 1ns/1ps

// one pipeline hop: the tag of the row/count being worked on plus the
// producer's register file
interface stageLinkIf import idctPkg::*; ();

   logic       enable;                       // block in progress
   page_t      page;                         // row tag
   count_t     count;                        // cycle within row
   stageWord_t lanes [LaneCount];            // producer register file

   modport src (
      output enable,
      output page,
      output count,
      output lanes
   );

   modport dst (
      input enable,
      input page,
      input count,
      input lanes
   );

endinterface

//--- verilog/blockSequencer.sv
`timescale 1ns/1ps

module blockSequencer import idctPkg::*; (
   input  logic   clk,
   input  logic   rst,
   input  logic   blockEnable,
   output logic   seqEnable,                 // high while a block runs
   output page_t  seqPage,
   output count_t seqCount,
   output logic   blockBank,                 // flips once per finished block
   output logic   blockIdle,
   output logic   blockRelease               // last cycle of the block
);

   logic pageEnd;
   logic blockEnd;

   assign pageEnd  = seqCount == count_t'(CountLast);
   assign blockEnd = pageEnd && seqPage == page_t'(PageLast);

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         seqEnable <= 1'b0;
         seqPage   <= '0;
         seqCount  <= '0;
         blockBank <= 1'b0;
      end else if (!seqEnable) begin
         if (blockEnable) begin               // start on next edge
            seqEnable <= 1'b1;
            seqPage   <= '0;
            seqCount  <= '0;
         end
      end else if (pageEnd) begin
         seqCount <= '0;
         if (blockEnd) begin                  // wrap up, back to idle
            seqEnable <= 1'b0;
            seqPage   <= '0;
            blockBank <= ~blockBank;
         end else begin
            seqPage <= seqPage + 1'b1;
         end
      end else begin
         seqCount <= seqCount + 1'b1;         // enable ignored while busy
      end
   end

   assign blockIdle    = !seqEnable;
   assign blockRelease = seqEnable && blockEnd;

   // 7-cycle row, never runs past count 6
   countRange: assert property (@(posedge clk) disable iff (!rst)
      seqCount <= count_t'(CountLast));

endmodule

//--- verilog/coeffMultiplier.sv
`timescale 1ns/1ps

module coeffMultiplier import idctPkg::*; (
   input  logic   clk,
   input  logic   rst,
   input  logic   seqEnable,
   input  page_t  seqPage,
   input  count_t seqCount,
   input  block_t blockIn,
   stageLinkIf.src prodLink
);

   logic [2:0] col0;                         // column of operand R0
   logic [2:0] col1;                         // column of operand R1
   coeffWord_t r0;
   coeffWord_t r1;
   coeffWord_t cosA;                         // K0 and K3
   coeffWord_t cosB;                         // K1 and K2
   stageWord_t prodReg [PairCount];

   //--------------------------------------------------------------------------
   // operand and cosine selection by count
   //--------------------------------------------------------------------------
   always_comb begin
      col0 = 3'd0;
      col1 = 3'd4;
      cosA = '0;                             // counts 4..6 give zero products
      cosB = '0;
      case (seqCount)
         count_t'(0): begin                  // even part, x0/x4
            col0 = 3'd0;
            col1 = 3'd4;
            cosA = CosC4;
            cosB = CosC4;
         end
         count_t'(1): begin                  // even part, x2/x6
            col0 = 3'd2;
            col1 = 3'd6;
            cosA = CosC2;
            cosB = CosC6;
         end
         count_t'(2): begin                  // odd part, x1/x7
            col0 = 3'd1;
            col1 = 3'd7;
            cosA = CosC1;
            cosB = CosC7;
         end
         count_t'(3): begin                  // odd part, x5/x3
            col0 = 3'd5;
            col1 = 3'd3;
            cosA = CosC5;
            cosB = CosC3;
         end
         default: ;
      endcase
   end

   assign r0 = blockIn[{seqPage, col0}];     // row base is 8*page
   assign r1 = blockIn[{seqPage, col1}];

   //--------------------------------------------------------------------------
   // four products, tag follows by one cycle
   //--------------------------------------------------------------------------
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         prodReg         <= '{default: '0};
         prodLink.enable <= 1'b0;
         prodLink.page   <= '0;
         prodLink.count  <= '0;
      end else begin
         prodReg[0]      <= r0 * cosA;
         prodReg[1]      <= r1 * cosB;
         prodReg[2]      <= r0 * cosB;
         prodReg[3]      <= r1 * cosA;
         prodLink.enable <= seqEnable;
         prodLink.page   <= seqPage;
         prodLink.count  <= seqCount;
      end
   end

   always_comb begin
      prodLink.lanes = '{default: '0};      // upper lanes unused
      for (int i = 0; i < PairCount; i++) begin
         prodLink.lanes[i] = prodReg[i];
      end
   end

endmodule

//--- verilog/sumStage.sv
`timescale 1ns/1ps

module sumStage import idctPkg::*; (
   input  logic    clk,
   input  logic    rst,
   stageLinkIf.dst prodLink,
   stageLinkIf.src sumLink
);

   stageWord_t sumA;                         // P0 + P1
   stageWord_t sumB;                         // P2 - P3
   logic       sumWrite;
   logic [2:0] idxA;
   logic [2:0] idxB;
   logic       enableD;
   page_t      pageD;
   count_t     countD;
   stageWord_t sReg [LaneCount];

   assign sumA     = prodLink.lanes[0] + prodLink.lanes[1];
   assign sumB     = prodLink.lanes[2] - prodLink.lanes[3];
   assign sumWrite = prodLink.enable && prodLink.count < PairCount;

   // destination slots per count
   always_comb begin
      case (prodLink.count[1:0])
         2'd0:    begin idxA = 3'd0; idxB = 3'd1; end
         2'd1:    begin idxA = 3'd3; idxB = 3'd2; end
         2'd2:    begin idxA = 3'd7; idxB = 3'd4; end
         default: begin idxA = 3'd6; idxB = 3'd5; end
      endcase
   end

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         sReg           <= '{default: '0};
         enableD        <= 1'b0;
         pageD          <= '0;
         countD         <= '0;
         sumLink.enable <= 1'b0;
         sumLink.page   <= '0;
         sumLink.count  <= '0;
      end else begin
         if (sumWrite) begin
            sReg[idxA] <= sumA;
            sReg[idxB] <= sumB;
         end
         enableD        <= prodLink.enable;  // two-cycle tag delay
         pageD          <= prodLink.page;
         countD         <= prodLink.count;
         sumLink.enable <= enableD;
         sumLink.page   <= pageD;
         sumLink.count  <= countD;
      end
   end

   assign sumLink.lanes = sReg;

   // a row's four writes on counts 0..3 run back to back
   writeRun: assert property (@(posedge clk) disable iff (!rst)
      (sumWrite && prodLink.count == '0) |=> sumWrite [*3] ##1 !sumWrite);

endmodule

//--- verilog/butterflyStage.sv
`timescale 1ns/1ps

module butterflyStage import idctPkg::*; (
   input  logic    clk,
   input  logic    rst,
   stageLinkIf.dst sumLink,
   stageLinkIf.src flyLink
);

   logic [2:0] idxA;                         // read and write slot, sum
   logic [2:0] idxB;                         // read and write slot, difference
   logic       flyWrite;
   stageWord_t flySum;
   stageWord_t flyDiff;
   logic       enableD;
   page_t      pageD;
   count_t     countD;
   stageWord_t tReg [LaneCount];

   // t slots line up with the s slots they come from
   always_comb begin
      case (sumLink.count[1:0])
         2'd0:    begin idxA = 3'd0; idxB = 3'd3; end
         2'd1:    begin idxA = 3'd1; idxB = 3'd2; end
         2'd2:    begin idxA = 3'd4; idxB = 3'd5; end
         default: begin idxA = 3'd7; idxB = 3'd6; end
      endcase
   end

   assign flyWrite = sumLink.enable && sumLink.count < PairCount;
   assign flySum   = sumLink.lanes[idxA] + sumLink.lanes[idxB];
   assign flyDiff  = sumLink.lanes[idxA] - sumLink.lanes[idxB];

   //--------------------------------------------------------------------------
   // t register file and tag delay
   //--------------------------------------------------------------------------
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         tReg           <= '{default: '0};
         enableD        <= 1'b0;
         pageD          <= '0;
         countD         <= '0;
         flyLink.enable <= 1'b0;
         flyLink.page   <= '0;
         flyLink.count  <= '0;
      end else begin
         if (flyWrite) begin
            tReg[idxA] <= flySum;
            tReg[idxB] <= flyDiff;
         end
         enableD        <= sumLink.enable;
         pageD          <= sumLink.page;
         countD         <= sumLink.count;
         flyLink.enable <= enableD;
         flyLink.page   <= pageD;
         flyLink.count  <= countD;
      end
   end

   assign flyLink.lanes = tReg;

endmodule

//--- verilog/outputStage.sv
`timescale 1ns/1ps

module outputStage import idctPkg::*; (
   input  logic       clk,
   input  logic       rst,
   stageLinkIf.dst    flyLink,
   output logic       outValid,
   output page_t      outPage,
   output logic [1:0] outCount,
   output outWord_t   out0,
   output outWord_t   out1
);

   rotWord_t   rotSum;                       // u0 = (t6 + t5) * 181
   rotWord_t   rotDiff;                      // u1 = (t6 - t5) * 181
   stageWord_t fly0;
   stageWord_t fly1;
   stageWord_t finalSum;
   stageWord_t finalDiff;
   logic       enableD [3];                  // [1] selects, [2] is the output tag
   page_t      pageD [3];
   count_t     countD [3];

   //--------------------------------------------------------------------------
   // rotation, t5/t6 of this row are ready on count 2
   //--------------------------------------------------------------------------
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         rotSum  <= '0;
         rotDiff <= '0;
      end else if (flyLink.enable && flyLink.count == count_t'(2)) begin
         rotSum  <= (flyLink.lanes[6] + flyLink.lanes[5]) * RotFactor;
         rotDiff <= (flyLink.lanes[6] - flyLink.lanes[5]) * RotFactor;
      end
   end

   // final butterfly operands, two cycles behind the link tag
   always_comb begin
      fly0 = '0;
      fly1 = '0;
      case (countD[1])
         count_t'(0): begin
            fly0 = flyLink.lanes[0];
            fly1 = flyLink.lanes[7];
         end
         count_t'(1): begin
            fly0 = flyLink.lanes[1];
            fly1 = stageWord_t'(rotSum >>> RotShift);
         end
         count_t'(2): begin
            fly0 = flyLink.lanes[2];
            fly1 = stageWord_t'(rotDiff >>> RotShift);
         end
         count_t'(3): begin
            fly0 = flyLink.lanes[3];
            fly1 = flyLink.lanes[4];
         end
         default: ;                          // counts 4..6 never leave
      endcase
   end

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         enableD   <= '{default: 1'b0};
         pageD     <= '{default: '0};
         countD    <= '{default: '0};
         finalSum  <= '0;
         finalDiff <= '0;
      end else begin
         enableD   <= '{flyLink.enable, enableD[0], enableD[1]};
         pageD     <= '{flyLink.page, pageD[0], pageD[1]};
         countD    <= '{flyLink.count, countD[0], countD[1]};
         finalSum  <= fly0 + fly1;           // index count
         finalDiff <= fly0 - fly1;           // index 7 - count
      end
   end

   assign outValid = enableD[2] && countD[2] < PairCount;
   assign outPage  = pageD[2];
   assign outCount = countD[2][1:0];
   assign out0     = finalSum[OutLsb+8:OutLsb];
   assign out1     = finalDiff[OutLsb+8:OutLsb];

   // beats of a row leave as counts 0..3 back to back on one page
   beatRun: assert property (@(posedge clk) disable iff (!rst)
      (outValid && outCount != 2'd3) |=> outValid && outCount == $past(outCount) + 2'd1
                                          && outPage == $past(outPage));

endmodule

//--- verilog/idctColumn.sv
`timescale 1ns/1ps

module idctColumn import idctPkg::*; (
   input  logic        clk,
   input  logic        rst,
   input  logic        blockEnable,         // level, sampled while idle
   input  block_t      blockIn,             // held until blockRelease
   output logic        blockBank,
   output logic        blockIdle,
   output logic        blockRelease,
   output logic        outValid,
   output page_t       outPage,
   output logic [1:0]  outCount,
   output outWord_t    out0,                // result index count
   output outWord_t    out1                 // result index 7 - count
);

   logic   seqEnable;
   page_t  seqPage;
   count_t seqCount;

   stageLinkIf prodLink ();                  // products, lanes 0..3
   stageLinkIf sumLink ();                   // s0..s7
   stageLinkIf flyLink ();                   // t0..t7

   blockSequencer blockSequencer_inst (
      .clk          (clk),
      .rst          (rst),
      .blockEnable  (blockEnable),
      .seqEnable    (seqEnable),
      .seqPage      (seqPage),
      .seqCount     (seqCount),
      .blockBank    (blockBank),
      .blockIdle    (blockIdle),
      .blockRelease (blockRelease)
   );

   coeffMultiplier coeffMultiplier_inst (
      .clk       (clk),
      .rst       (rst),
      .seqEnable (seqEnable),
      .seqPage   (seqPage),
      .seqCount  (seqCount),
      .blockIn   (blockIn),
      .prodLink  (prodLink.src)
   );

   sumStage sumStage_inst (
      .clk      (clk),
      .rst      (rst),
      .prodLink (prodLink.dst),
      .sumLink  (sumLink.src)
   );

   butterflyStage butterflyStage_inst (
      .clk     (clk),
      .rst     (rst),
      .sumLink (sumLink.dst),
      .flyLink (flyLink.src)
   );

   outputStage outputStage_inst (
      .clk      (clk),
      .rst      (rst),
      .flyLink  (flyLink.dst),
      .outValid (outValid),
      .outPage  (outPage),
      .outCount (outCount),
      .out0     (out0),
      .out1     (out1)
   );

endmodule

//--- tests/idctColumnTb.sv
`timescale 1ns/1ps

module idctColumnTb import idctPkg::*; ();

   localparam int BlocksTested  = 21;          // dc 1, impulse 8, random 8, control 1 + 3
   localparam int TimeoutCycles = 70 * BlocksTested + 200;
   localparam int BeatsPerBlock = PageCount * PairCount;
   localparam int ChainLength   = 3;           // back-to-back blocks

   logic        clk;
   logic        rst;
   logic        blockEnable;
   block_t      blockIn;
   logic        blockBank;
   logic        blockIdle;
   logic        blockRelease;
   logic        outValid;
   page_t       outPage;
   logic [1:0]  outCount;
   outWord_t    out0;
   outWord_t    out1;

   block_t      blockSet [ChainLength];        // stimulus slots, slot 0 for single runs
   page_t       beatPage [$];                  // captured output beats
   logic [1:0]  beatCount [$];
   outWord_t    beatOut0 [$];
   outWord_t    beatOut1 [$];
   int          releaseCount;
   int          bankToggles;
   logic        lastBank;
   int          cycleCount;
   logic [15:0] lfsrState;

   idctColumn idctColumn_inst (
      .clk          (clk),
      .rst          (rst),
      .blockEnable  (blockEnable),
      .blockIn      (blockIn),
      .blockBank    (blockBank),
      .blockIdle    (blockIdle),
      .blockRelease (blockRelease),
      .outValid     (outValid),
      .outPage      (outPage),
      .outCount     (outCount),
      .out0         (out0),
      .out1         (out1)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;                  // 40 ns period
   end

   //--------------------------------------------------------------------------
   // monitor and timeout
   //--------------------------------------------------------------------------
   always @(negedge clk) begin                 // outputs settled mid-cycle
      if (outValid) begin
         beatPage.push_back(outPage);
         beatCount.push_back(outCount);
         beatOut0.push_back(out0);
         beatOut1.push_back(out1);
      end
      if (blockRelease) begin
         releaseCount++;                       // counts high cycles, so a wide pulse shows
      end
      if (blockBank !== lastBank) begin
         bankToggles++;
      end
      lastBank = blockBank;
   end

   always @(posedge clk) begin
      cycleCount++;
      if (cycleCount > TimeoutCycles) begin
         reportError($sformatf("timeout after %0d cycles, DUT stopped making progress",
                               TimeoutCycles));
      end
   end

   //--------------------------------------------------------------------------
   // error reporting and compare tasks
   //--------------------------------------------------------------------------
   task automatic reportError(input string line);
      $display("%s", line);
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic checkOut(input string name, input outWord_t got, input outWord_t exp);
      if (got !== exp) begin
         reportError($sformatf("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
      end
   endtask

   task automatic checkTag(input string where, input page_t gotPage, input logic [1:0] gotCount,
                           input page_t expPage, input logic [1:0] expCount);
      if (gotPage !== expPage) begin
         reportError($sformatf("mismatch outPage at %s: got 0x%0h expected 0x%0h",
                               where, gotPage, expPage));
      end
      if (gotCount !== expCount) begin
         reportError($sformatf("mismatch outCount at %s: got 0x%0h expected 0x%0h",
                               where, gotCount, expCount));
      end
   endtask

   task automatic checkFlag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         reportError($sformatf("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
      end
   endtask

   task automatic checkTotal(input string name, input int got, input int exp);
      if (got != exp) begin
         reportError($sformatf("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
      end
   endtask

   //--------------------------------------------------------------------------
   // reference column pass, one result word of one row
   //--------------------------------------------------------------------------
   function automatic outWord_t modelResult(input int slot, input int page, input int idx);
      longint x [8];
      longint s [8];
      longint t [8];
      longint cosK [8];
      longint u0;
      longint u1;
      longint a;
      longint b;
      longint r;
      int     c;
      cosK[0] = 0;
      cosK[1] = CosC1;
      cosK[2] = CosC2;
      cosK[3] = CosC3;
      cosK[4] = CosC4;
      cosK[5] = CosC5;
      cosK[6] = CosC6;
      cosK[7] = CosC7;
      for (int k = 0; k < 8; k++) begin
         x[k] = longint'(blockSet[slot][8 * page + k]);
      end
      s[0] = x[0] * cosK[4] + x[4] * cosK[4];  // even part
      s[1] = x[0] * cosK[4] - x[4] * cosK[4];
      s[3] = x[2] * cosK[2] + x[6] * cosK[6];
      s[2] = x[2] * cosK[6] - x[6] * cosK[2];
      s[7] = x[1] * cosK[1] + x[7] * cosK[7];  // odd part
      s[4] = x[1] * cosK[7] - x[7] * cosK[1];
      s[6] = x[5] * cosK[5] + x[3] * cosK[3];
      s[5] = x[5] * cosK[3] - x[3] * cosK[5];
      t[0] = s[0] + s[3];
      t[3] = s[0] - s[3];
      t[1] = s[1] + s[2];
      t[2] = s[1] - s[2];
      t[4] = s[4] + s[5];
      t[5] = s[4] - s[5];
      t[7] = s[7] + s[6];
      t[6] = s[7] - s[6];
      u0 = ((t[6] + t[5]) * longint'(RotFactor)) >>> RotShift;  // 181/256 rotation
      u1 = ((t[6] - t[5]) * longint'(RotFactor)) >>> RotShift;
      c = (idx < 4) ? idx : 7 - idx;
      case (c)
         0:       begin a = t[0]; b = t[7]; end
         1:       begin a = t[1]; b = u0;   end
         2:       begin a = t[2]; b = u1;   end
         default: begin a = t[3]; b = t[4]; end
      endcase
      r = (idx < 4) ? a + b : a - b;           // low half sums, high half differences
      return outWord_t'(r >>> OutLsb);
   endfunction

   // 16 bit Galois LFSR, one step per bit taken
   function automatic logic [15:0] lfsrStep(input logic [15:0] state);
      logic [15:0] next;
      next = state >> 1;
      if (state[0]) begin
         next = next ^ 16'hB400;
      end
      return next;
   endfunction

   function automatic int takeBits(input int bits);
      int value;
      value = 0;
      for (int i = 0; i < bits; i++) begin
         lfsrState = lfsrStep(lfsrState);
         value = (value << 1) | int'(lfsrState[0]);
      end
      return value;
   endfunction

   //--------------------------------------------------------------------------
   // block runs
   //--------------------------------------------------------------------------
   task automatic clearBeats();
      beatPage.delete();
      beatCount.delete();
      beatOut0.delete();
      beatOut1.delete();
   endtask

   task automatic waitBeats(input int total);
      while (beatOut0.size() < total) begin
         @(negedge clk);                       // timeout guards a stall
      end
      repeat (4) @(negedge clk);               // room for a stray extra beat
   endtask

   task automatic compareBlock(input int slot, input int first);
      int p;
      int c;
      for (int i = 0; i < BeatsPerBlock; i++) begin
         p = i / PairCount;                    // beats in page order
         c = i % PairCount;
         checkTag($sformatf("beat %0d", first + i), beatPage[first + i],
                  beatCount[first + i], page_t'(p), 2'(c));
         checkOut($sformatf("out0 page %0d index %0d", p, c), beatOut0[first + i],
                  modelResult(slot, p, c));
         checkOut($sformatf("out1 page %0d index %0d", p, 7 - c), beatOut1[first + i],
                  modelResult(slot, p, 7 - c));
      end
   endtask

   task automatic runSingle(input bit strayEnable);
      int releases;
      int toggles;
      clearBeats();
      releases = releaseCount;
      toggles  = bankToggles;
      checkFlag("blockIdle", blockIdle, 1'b1);
      blockIn     = blockSet[0];
      blockEnable = 1'b1;
      @(negedge clk);
      blockEnable = 1'b0;
      checkFlag("blockIdle", blockIdle, 1'b0);
      if (strayEnable) begin
         repeat (20) @(negedge clk);
         blockEnable = 1'b1;                   // busy, must not restart
         @(negedge clk);
         blockEnable = 1'b0;
      end
      waitBeats(BeatsPerBlock);
      checkFlag("blockIdle", blockIdle, 1'b1);
      checkTotal("blockRelease pulses", releaseCount - releases, 1);
      checkTotal("blockBank toggles", bankToggles - toggles, 1);
      checkTotal("output beats", beatOut0.size(), BeatsPerBlock);
      compareBlock(0, 0);
   endtask

   task automatic runChain();
      int releases;
      int toggles;
      clearBeats();
      releases    = releaseCount;
      toggles     = bankToggles;
      blockIn     = blockSet[0];
      blockEnable = 1'b1;                      // held across all blocks
      for (int b = 0; b < ChainLength; b++) begin
         do begin
            @(negedge clk);
         end while (!blockRelease);
         if (b < ChainLength - 1) begin
            blockIn = blockSet[b + 1];         // next block starts after the idle cycle
         end else begin
            blockEnable = 1'b0;
         end
         @(negedge clk);
         checkFlag("blockIdle", blockIdle, 1'b1);
      end
      waitBeats(ChainLength * BeatsPerBlock);
      checkTotal("blockRelease pulses", releaseCount - releases, ChainLength);
      checkTotal("blockBank toggles", bankToggles - toggles, ChainLength);
      checkTotal("output beats", beatOut0.size(), ChainLength * BeatsPerBlock);
      for (int b = 0; b < ChainLength; b++) begin
         compareBlock(b, b * BeatsPerBlock);
      end
   endtask

   task automatic fillRandom(input int slot);
      for (int i = 0; i < BlockSize; i++) begin
         blockSet[slot][i] = coeffWord_t'(takeBits(11) - 1024);  // -1024..1023
      end
   endtask

   //--------------------------------------------------------------------------
   // directed tests
   //--------------------------------------------------------------------------
   task automatic testReset();
      checkFlag("blockIdle", blockIdle, 1'b1);
      checkFlag("blockRelease", blockRelease, 1'b0);
      checkFlag("outValid", outValid, 1'b0);
      checkFlag("blockBank", blockBank, 1'b0);
   endtask

   task automatic testDcBlock();
      blockSet[0] = '{default: '0};
      for (int p = 0; p < PageCount; p++) begin
         blockSet[0][8 * p] = coeffWord_t'(3000 - 900 * p);  // crosses zero
      end
      runSingle(1'b0);
   endtask

   task automatic testImpulses();
      for (int k = 0; k < 8; k++) begin
         blockSet[0] = '{default: '0};
         for (int p = 0; p < PageCount; p++) begin
            blockSet[0][8 * p + k] = (k % 2 == 0) ? coeffWord_t'(12000 - 1000 * k)
                                                  : coeffWord_t'(-5000 - 700 * k);
         end
         runSingle(1'b0);
      end
   endtask

   task automatic testRandomBlocks();
      for (int n = 0; n < 8; n++) begin
         fillRandom(0);
         runSingle(1'b0);
      end
   endtask

   task automatic testControl();
      fillRandom(0);
      runSingle(1'b1);                         // enable pulse mid-block
      for (int b = 0; b < ChainLength; b++) begin
         fillRandom(b);
      end
      runChain();
   endtask

   initial begin
      rst          = 1'b0;                     // reset held from time zero
      blockEnable  = 1'b0;
      blockIn      = '{default: '0};
      releaseCount = 0;
      bankToggles  = 0;
      lastBank     = 1'b0;
      cycleCount   = 0;
      lfsrState    = 16'd81;
      repeat (5) @(negedge clk);
      rst = 1'b1;
      @(negedge clk);
      testReset();
      testDcBlock();
      testImpulses();
      testRandomBlocks();
      testControl();
      $display("Simulation completed successfully");
      $finish;
   end

endmodule

//--- sim.f
verilog/idctPkg.sv
verilog/stageLinkIf.sv
verilog/blockSequencer.sv
verilog/coeffMultiplier.sv
verilog/sumStage.sv
verilog/butterflyStage.sv
verilog/outputStage.sv
verilog/idctColumn.sv
tests/idctColumnTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= idctColumnTb
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' sim.f)
BIN     := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) sim.f
	$(VERILATOR) $(VFLAGS) -f sim.f --top-module $(TOP) --Mdir $(OBJDIR)

run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
